// File: files.f
hdl/fp_format_pkg.sv
hdl/fpu_op_pkg.sv
hdl/fp_unpack.sv
hdl/fp_compare_minmax.sv
hdl/fp_result_select.sv
hdl/fp_flag_csr.sv
hdl/fpu_top.sv
sim/tb_clock_gen.sv
sim/fpu_top_tb.sv

// File: hdl/fp_compare_minmax.sv
// Compare and min/max unit
// One ordering network serves FEQ/FLT/FLE and FMIN/FMAX,
// plus the invalid flags of both operation groups

`timescale 1ns/1ps

module fp_compare_minmax import fp_format_pkg::*; (
  input  fp32_t    operand_a,
  input  fp32_t    operand_b,
  input  fp_info_t info_a,
  input  fp_info_t info_b,
  input  logic     minmax_is_max,     // 1 selects FMAX, 0 FMIN
  output logic     cmp_lt,            // a < b, false with any NaN
  output logic     cmp_eq,            // a == b, false with any NaN
  output fp32_t    minmax_result,
  output logic     cmp_nv_signaling,  // FLT/FLE invalid
  output logic     cmp_nv_quiet,      // FEQ invalid
  output logic     minmax_nv
);

  logic [30:0] mag_a;       // Exponent and fraction, sign dropped
  logic [30:0] mag_b;
  logic        both_zero;   // +0/-0 in any combination
  logic        any_nan;
  logic        any_snan;
  logic        sign_diff;
  logic        lt_total;    // a < b with -0 ordered below +0

  assign mag_a     = {operand_a.exponent, operand_a.mantissa};
  assign mag_b     = {operand_b.exponent, operand_b.mantissa};
  assign both_zero = info_a.is_zero & info_b.is_zero;
  assign any_nan   = info_a.is_nan | info_b.is_nan;
  assign any_snan  = info_a.is_snan | info_b.is_snan;
  assign sign_diff = operand_a.sign ^ operand_b.sign;

  // ==================================================
  // Sign-magnitude ordering
  // ==================================================
  always_comb begin
    if (sign_diff) begin
      lt_total = operand_a.sign;        // Negative a is below positive b
    end else if (operand_a.sign) begin
      lt_total = (mag_a > mag_b);       // Both negative, larger magnitude is smaller
    end else begin
      lt_total = (mag_a < mag_b);       // Both positive
    end
  end

  // Compare results, -0 and +0 equal for compares
  assign cmp_lt = ~any_nan & lt_total & ~both_zero;
  assign cmp_eq = ~any_nan & (both_zero | (operand_a == operand_b));

  // ==================================================
  // FMIN / FMAX
  // ==================================================
  always_comb begin
    if (info_a.is_nan && info_b.is_nan) begin
      minmax_result = CANON_NAN;
    end else if (info_a.is_nan) begin
      minmax_result = operand_b;        // NaN loses to a number
    end else if (info_b.is_nan) begin
      minmax_result = operand_a;
    end else if (minmax_is_max) begin
      minmax_result = lt_total ? operand_b : operand_a;  // Max picks +0 over -0
    end else begin
      minmax_result = lt_total ? operand_a : operand_b;  // Min picks -0 over +0
    end
  end

  // Invalid flags
  // Quiet ops trap on sNaN only, FLT/FLE on any NaN
  assign minmax_nv        = any_snan;
  assign cmp_nv_quiet     = any_snan;
  assign cmp_nv_signaling = any_nan;

endmodule

// File: hdl/fp_flag_csr.sv
// Sticky exception flag register (fflags)
// ORs in the flags of every finished operation, cleared by software

`timescale 1ns/1ps

module fp_flag_csr import fpu_op_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      done,          // Flags below are valid
  input  fp_flags_t flags,         // Flags of the finished operation
  input  logic      fflags_clear,  // Software clear
  output fp_flags_t fflags
);

  // ==================================================
  // Accumulate
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fflags <= '0;
    end else if (done) begin
      // Clear wins over old state, not over the new result
      fflags <= fflags_clear ? flags : (fflags | flags);
    end else if (fflags_clear) begin
      fflags <= '0;
    end
  end

endmodule

// File: hdl/fp_format_pkg.sv
// Single-precision IEEE 754 format definitions
// Field widths, operand layout, decoded class flags and the canonical NaN

package fp_format_pkg;

  // ==================================================
  // Field widths
  // ==================================================
  localparam int EXP_W = 8;   // Biased exponent
  localparam int MAN_W = 23;  // Stored fraction, hidden bit not included

  // Raw operand as held in the FP register file
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exponent;
    logic [MAN_W-1:0] mantissa;
  } fp32_t;

  // ==================================================
  // Decoded operand classes
  // ==================================================
  // Exactly one of zero/subnormal/normal/inf/nan is set,
  // snan and qnan only refine a NaN
  typedef struct packed {
    logic is_neg;        // Sign bit, also for NaN
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_snan;       // Quiet bit clear
    logic is_qnan;       // Quiet bit set
  } fp_info_t;

  // Canonical quiet NaN, RISC-V default NaN
  localparam fp32_t CANON_NAN = 32'h7FC0_0000;

endpackage

// File: hdl/fp_result_select.sv
// Result select and output register
// Decodes the opcode, builds sign-injection and FCLASS results,
// picks the result fields and registers them with a done pulse

`timescale 1ns/1ps

module fp_result_select import fp_format_pkg::*; import fpu_op_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  fp_op_e      op,
  input  fp32_t       operand_a,
  input  fp32_t       operand_b,
  input  logic [31:0] int_operand,
  input  fp_info_t    info_a,
  input  logic        cmp_lt,
  input  logic        cmp_eq,
  input  fp32_t       minmax_result,
  input  logic        cmp_nv_signaling,
  input  logic        cmp_nv_quiet,
  input  logic        minmax_nv,
  output logic        minmax_is_max,  // Steers the shared min/max mux
  output logic        done,
  output fpu_resp_t   resp
);

  fp32_t     sgnj_result;   // Sign-injection result
  logic [9:0] class_mask;   // One-hot FCLASS result
  fpu_resp_t resp_next;     // Value loaded on start

  assign minmax_is_max = (op == FP_MAX);

  // ==================================================
  // Sign injection
  // ==================================================
  always_comb begin
    sgnj_result = operand_a;  // Magnitude always from a
    case (op)
      FP_SGNJN: sgnj_result.sign = ~operand_b.sign;
      FP_SGNJX: sgnj_result.sign = operand_a.sign ^ operand_b.sign;
      default:  sgnj_result.sign = operand_b.sign;  // FSGNJ
    endcase
  end

  // FCLASS mask, bit 0 is -inf up to bit 9 qNaN
  assign class_mask[0] = info_a.is_neg & info_a.is_inf;
  assign class_mask[1] = info_a.is_neg & info_a.is_normal;
  assign class_mask[2] = info_a.is_neg & info_a.is_subnormal;
  assign class_mask[3] = info_a.is_neg & info_a.is_zero;
  assign class_mask[4] = ~info_a.is_neg & info_a.is_zero;
  assign class_mask[5] = ~info_a.is_neg & info_a.is_subnormal;
  assign class_mask[6] = ~info_a.is_neg & info_a.is_normal;
  assign class_mask[7] = ~info_a.is_neg & info_a.is_inf;
  assign class_mask[8] = info_a.is_snan;  // Sign ignored for NaN
  assign class_mask[9] = info_a.is_qnan;

  // ==================================================
  // Result mux
  // ==================================================
  always_comb begin
    resp_next = '0;  // Unused fields stay zero
    case (op)
      FP_SGNJ, FP_SGNJN, FP_SGNJX: begin
        resp_next.fp_result = sgnj_result;  // No exceptions
      end
      FP_MIN, FP_MAX: begin
        resp_next.fp_result = minmax_result;
        resp_next.flags.nv  = minmax_nv;
      end
      FP_FEQ: begin
        resp_next.int_result = {31'd0, cmp_eq};
        resp_next.flags.nv   = cmp_nv_quiet;
      end
      FP_FLT: begin
        resp_next.int_result = {31'd0, cmp_lt};
        resp_next.flags.nv   = cmp_nv_signaling;
      end
      FP_FLE: begin
        resp_next.int_result = {31'd0, cmp_lt | cmp_eq};
        resp_next.flags.nv   = cmp_nv_signaling;
      end
      FP_CLASS: resp_next.int_result = {22'd0, class_mask};
      FP_MV_XW: resp_next.int_result = operand_a;     // Raw bits, no NaN check
      FP_MV_WX: resp_next.fp_result  = int_operand;
      default:  resp_next.flags.nv   = 1'b1;          // Illegal opcode
    endcase
  end

  // ==================================================
  // Output register
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
      resp <= '0;
    end else begin
      done <= start;         // One pulse per accepted start
      if (start) begin
        resp <= resp_next;   // Held until next start
      end
    end
  end

endmodule

// File: hdl/fp_unpack.sv
// Operand unpack
// Splits one single-precision operand into fields and
// marks its IEEE 754 class

`timescale 1ns/1ps

module fp_unpack import fp_format_pkg::*; (
  input  fp32_t    operand,
  output fp_info_t info
);

  logic exp_zero;   // Exponent all zeros
  logic exp_ones;   // Exponent all ones
  logic man_zero;   // Fraction all zeros

  assign exp_zero = (operand.exponent == '0);
  assign exp_ones = (operand.exponent == '1);
  assign man_zero = (operand.mantissa == '0);

  // ==================================================
  // Class decode
  // ==================================================
  always_comb begin
    info              = '0;
    info.is_neg       = operand.sign;
    info.is_zero      = exp_zero & man_zero;
    info.is_subnormal = exp_zero & ~man_zero;  // No hidden bit
    info.is_normal    = ~exp_zero & ~exp_ones;
    info.is_inf       = exp_ones & man_zero;
    info.is_nan       = exp_ones & ~man_zero;
    // Quiet bit is the top fraction bit
    info.is_snan      = info.is_nan & ~operand.mantissa[MAN_W-1];
    info.is_qnan      = info.is_nan & operand.mantissa[MAN_W-1];
  end

endmodule

// File: hdl/fpu_op_pkg.sv
// FPU operation definitions
// Opcodes of the single-cycle operations, exception flags in fflags order
// and the registered response bundle

package fpu_op_pkg;

  // ==================================================
  // Operation codes
  // ==================================================
  // Codes 5..18 match the control unit encoding,
  // compares get their own codes instead of a funct3 decode
  typedef enum logic [4:0] {
    FP_SGNJ  = 5'd5,
    FP_SGNJN = 5'd6,
    FP_SGNJX = 5'd7,
    FP_MIN   = 5'd8,
    FP_MAX   = 5'd9,
    FP_CLASS = 5'd12,
    FP_MV_XW = 5'd17,   // FMV.X.W, FP bits to int
    FP_MV_WX = 5'd18,   // FMV.W.X, int bits to FP
    FP_FEQ   = 5'd19,
    FP_FLT   = 5'd20,
    FP_FLE   = 5'd21
  } fp_op_e;            // Any other code is illegal

  // ==================================================
  // Exception flags, nv in the MSB as in fflags
  // ==================================================
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero, never raised here
    logic of;  // Overflow, never raised here
    logic uf;  // Underflow, never raised here
    logic nx;  // Inexact, never raised here
  } fp_flags_t;

  // Registered result of one operation
  typedef struct packed {
    logic [31:0] fp_result;   // To FP register file
    logic [31:0] int_result;  // To integer register file
    fp_flags_t   flags;
  } fpu_resp_t;

endpackage

// File: hdl/fpu_top.sv
// Single-cycle FPU top level
// Sign injection, min/max, compare, classify and bit moves for RV32F,
// with a sticky fflags register beside the result stage

`timescale 1ns/1ps

module fpu_top import fp_format_pkg::*; import fpu_op_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  fp_op_e      op,
  input  fp32_t       operand_a,
  input  fp32_t       operand_b,
  input  logic [31:0] int_operand,
  input  logic        fflags_clear,
  output logic        done,
  output fpu_resp_t   resp,
  output fp_flags_t   fflags
);

  fp_info_t info_a;            // Decoded classes of a
  fp_info_t info_b;            // Decoded classes of b
  logic     cmp_lt;
  logic     cmp_eq;
  fp32_t    minmax_result;
  logic     minmax_is_max;     // From decode back to min/max mux
  logic     cmp_nv_signaling;
  logic     cmp_nv_quiet;
  logic     minmax_nv;

  // ==================================================
  // Operand decode
  // ==================================================
  fp_unpack u_unpack_a (.operand(operand_a), .info(info_a));
  fp_unpack u_unpack_b (.operand(operand_b), .info(info_b));

  // Shared ordering for compares and min/max
  fp_compare_minmax u_compare_minmax (
    .operand_a        (operand_a),
    .operand_b        (operand_b),
    .info_a           (info_a),
    .info_b           (info_b),
    .minmax_is_max    (minmax_is_max),
    .cmp_lt           (cmp_lt),
    .cmp_eq           (cmp_eq),
    .minmax_result    (minmax_result),
    .cmp_nv_signaling (cmp_nv_signaling),
    .cmp_nv_quiet     (cmp_nv_quiet),
    .minmax_nv        (minmax_nv)
  );

  // ==================================================
  // Result stage and flag register
  // ==================================================
  fp_result_select u_result_select (
    .clk              (clk),
    .rst_n            (rst_n),
    .start            (start),
    .op               (op),
    .operand_a        (operand_a),
    .operand_b        (operand_b),
    .int_operand      (int_operand),
    .info_a           (info_a),
    .cmp_lt           (cmp_lt),
    .cmp_eq           (cmp_eq),
    .minmax_result    (minmax_result),
    .cmp_nv_signaling (cmp_nv_signaling),
    .cmp_nv_quiet     (cmp_nv_quiet),
    .minmax_nv        (minmax_nv),
    .minmax_is_max    (minmax_is_max),
    .done             (done),
    .resp             (resp)
  );

  fp_flag_csr u_flag_csr (
    .clk          (clk),
    .rst_n        (rst_n),
    .done         (done),
    .flags        (resp.flags),   // Registered flags of the done result
    .fflags_clear (fflags_clear),
    .fflags       (fflags)
  );

endmodule

// File: sim/fpu_stim.txt
# Columns, all hex: op operand_a operand_b int_operand exp_fp_result exp_int_result exp_flags
# op: 05 sgnj 06 sgnjn 07 sgnjx 08 min 09 max 0c class 11 mv.x.w 12 mv.w.x 13 feq 14 flt 15 fle
05 3F800000 C0000000 00000000 BF800000 00000000 00
06 3F800000 C0000000 00000000 3F800000 00000000 00
07 BF800000 C0000000 00000000 3F800000 00000000 00
05 00000000 80000000 00000000 80000000 00000000 00
06 7FC00000 00000000 00000000 FFC00000 00000000 00
08 3F800000 40000000 00000000 3F800000 00000000 00
09 C0400000 C0000000 00000000 C0000000 00000000 00
08 00000000 80000000 00000000 80000000 00000000 00
09 80000000 00000000 00000000 00000000 00000000 00
08 7FC00000 3F800000 00000000 3F800000 00000000 00
09 7FC00000 FFC00000 00000000 7FC00000 00000000 00
09 7F800001 3F800000 00000000 3F800000 00000000 10
13 3F800000 3F800000 00000000 00000000 00000001 00
13 00000000 80000000 00000000 00000000 00000001 00
13 7FC00000 3F800000 00000000 00000000 00000000 00
13 7F800001 3F800000 00000000 00000000 00000000 10
14 C0000000 3F800000 00000000 00000000 00000001 00
14 80000000 00000000 00000000 00000000 00000000 00
14 7FC00000 3F800000 00000000 00000000 00000000 10
15 80000000 00000000 00000000 00000000 00000001 00
15 40000000 3F800000 00000000 00000000 00000000 00
15 3F800000 FFC00000 00000000 00000000 00000000 10
0C FF800000 00000000 00000000 00000000 00000001 00
0C BF800000 00000000 00000000 00000000 00000002 00
0C 80000001 00000000 00000000 00000000 00000004 00
0C 80000000 00000000 00000000 00000000 00000008 00
0C 00000000 00000000 00000000 00000000 00000010 00
0C 00400000 00000000 00000000 00000000 00000020 00
0C 3F800000 00000000 00000000 00000000 00000040 00
0C 7F800000 00000000 00000000 00000000 00000080 00
0C 7F800001 00000000 00000000 00000000 00000100 00
0C 7FC00000 00000000 00000000 00000000 00000200 00
11 FFC00001 00000000 00000000 00000000 FFC00001 00
12 00000000 00000000 7F800001 7F800001 00000000 00
1F 3F800000 40000000 00000000 00000000 00000000 10
05 40490FDB 00000000 00000000 40490FDB 00000000 00

// File: sim/fpu_top_tb.sv
// Testbench for the single-cycle FPU
// Applies the vectors of the stimulus file back to back, checks every
// response on its done cycle and tracks the sticky fflags

`timescale 1ns/1ps

module fpu_top_tb import fp_format_pkg::*; import fpu_op_pkg::*; ();

  // One line of the stimulus file
  typedef struct packed {
    logic [4:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] int_op;
    logic [31:0] exp_fp;
    logic [31:0] exp_int;
    logic [4:0]  exp_flags;
  } stim_vec_t;

  logic        clk;
  logic        rst_n;
  logic        start;
  fp_op_e      op;
  fp32_t       operand_a;
  fp32_t       operand_b;
  logic [31:0] int_operand;
  logic        fflags_clear;
  logic        done;
  fpu_resp_t   resp;
  fp_flags_t   fflags;

  stim_vec_t   vecs[$];
  int          num_vec = 0;
  int          clear_idx;      // Vector index driven together with the clear pulse
  int          idx;
  logic [4:0]  acc_flags;      // Model of the sticky fflags

  tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

  fpu_top i_fpu_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .op           (op),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .int_operand  (int_operand),
    .fflags_clear (fflags_clear),
    .done         (done),
    .resp         (resp),
    .fflags       (fflags)
  );

  // ==================================================
  // Helpers
  // ==================================================
  function automatic string op_label(input logic [4:0] code);
    case (code)
      5'd5:    return "fsgnj";
      5'd6:    return "fsgnjn";
      5'd7:    return "fsgnjx";
      5'd8:    return "fmin";
      5'd9:    return "fmax";
      5'd12:   return "fclass";
      5'd17:   return "fmv.x.w";
      5'd18:   return "fmv.w.x";
      5'd19:   return "feq";
      5'd20:   return "flt";
      5'd21:   return "fle";
      default: return "illegal";
    endcase
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  // Skips blank lines and lines starting with #
  task automatic load_stimulus();
    int          fd;
    int          count;
    string       line;
    stim_vec_t   v;
    logic [31:0] f_op, f_a, f_b, f_int, f_fp, f_ires, f_flags;
    fd = $fopen("sim/fpu_stim.txt", "r");
    if (fd == 0) abort_run("cannot open stimulus file sim/fpu_stim.txt");
    while (!$feof(fd)) begin
      line = "";
      count = $fgets(line, fd);
      if (line.len() > 1 && line[0] != "#") begin
        count = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_op, f_a, f_b, f_int, f_fp, f_ires, f_flags);
        if (count != 7) abort_run($sformatf("malformed stimulus line: %s", line));
        v.op        = f_op[4:0];
        v.a         = f_a;
        v.b         = f_b;
        v.int_op    = f_int;
        v.exp_fp    = f_fp;
        v.exp_int   = f_ires;
        v.exp_flags = f_flags[4:0];
        vecs.push_back(v);
      end
    end
    $fclose(fd);
  endtask

  // Result of vector j is visible on the negedge after its sampling edge
  task automatic check_response(input int j);
    string name;
    name = $sformatf("vec%0d %s", j, op_label(vecs[j].op));
    @(negedge clk);
    if (done !== 1'b1) abort_run($sformatf("no done pulse for vector %0d", j));
    check({name, " fp_result"}, vecs[j].exp_fp, resp.fp_result);
    check({name, " int_result"}, vecs[j].exp_int, resp.int_result);
    check({name, " flags"}, {27'd0, vecs[j].exp_flags}, {27'd0, resp.flags});
    check({name, " fflags"}, {27'd0, acc_flags}, {27'd0, fflags});  // Up to vector j-1
    if (clear_idx == j + 1) acc_flags = vecs[j].exp_flags;  // Clear meets this done
    else                    acc_flags = acc_flags | vecs[j].exp_flags;
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    void'($urandom(32'h4569f30f));
    start        = 1'b0;
    op           = FP_SGNJ;
    operand_a    = '0;
    operand_b    = '0;
    int_operand  = '0;
    fflags_clear = 1'b0;
    acc_flags    = '0;
    load_stimulus();
    if (vecs.size() < 2) abort_run("stimulus file holds fewer than two vectors");
    clear_idx = 1 + int'($urandom % (vecs.size() - 1));
    num_vec   = vecs.size();                 // Arms the watchdog

    wait (rst_n === 1'b1);
    @(negedge clk);
    check("reset done", 32'd0, {31'd0, done});
    check("reset resp fp_result", 32'd0, resp.fp_result);
    check("reset resp int_result", 32'd0, resp.int_result);
    check("reset resp flags", 32'd0, {27'd0, resp.flags});
    check("reset fflags", 32'd0, {27'd0, fflags});

    for (idx = 0; idx <= num_vec; idx++) begin
      @(posedge clk);
      if (idx < num_vec) begin
        start        <= 1'b1;                // Back to back, one vector per cycle
        op           <= fp_op_e'(vecs[idx].op);
        operand_a    <= vecs[idx].a;
        operand_b    <= vecs[idx].b;
        int_operand  <= vecs[idx].int_op;
        fflags_clear <= (idx == clear_idx);
      end else begin
        start        <= 1'b0;
        fflags_clear <= 1'b0;
      end
      if (idx > 0) check_response(idx - 1);
    end

    @(posedge clk);
    @(negedge clk);
    check("idle done", 32'd0, {31'd0, done});
    check("final fflags", {27'd0, acc_flags}, {27'd0, fflags});
    $display("STATUS: PASS");
    $finish;
  end

  // Watchdog, 20 cycles per vector plus reset
  initial begin
    wait (num_vec > 0);
    repeat (20 * num_vec + 8) @(posedge clk);
    abort_run("watchdog timeout, the run did not finish in time");
  end

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and reset generator
// 8 ns clock, synchronous active-low reset held for 8 cycles

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 4;  // ns
  localparam int RESET_CYCLES = 8;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;                   // Release on a rising edge
  end

  always #HALF_PERIOD clk = ~clk;

endmodule
